//--- all.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/bp_pkg.sv
rtl/branch_route.sv
rtl/predictor_bank.sv
rtl/predict_select.sv
rtl/branch_predictor.sv
sim/bp_assertions.sv
sim/tb_branch_predictor.sv

//--- rtl/bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// branch target buffer geometry
// four banks of sixteen entries give the 64-entry table

`define BP_BANKS      4

`define BP_ENTRIES    16     // per bank

`define BP_TAG_W      8      // pc bits above index and bank

// counter state a freshly allocated entry steps from
`define BP_CNT_RESET  2'b00

`endif

//--- rtl/bp_pkg.sv
`default_nettype none

`include "bp_macros.svh"

package bp_pkg;

  import rv_isa_pkg::*;

  localparam int PC_W     = 32;
  localparam int NBANKS   = `BP_BANKS;
  localparam int NENTRIES = `BP_ENTRIES;
  localparam int TAG_W    = `BP_TAG_W;
  localparam int BANK_W   = $clog2(NBANKS);
  localparam int IDX_W    = $clog2(NENTRIES);
  localparam int HI_W     = PC_W - TAG_W - IDX_W - BANK_W - 2;

  localparam logic [1:0] CNT_RESET = `BP_CNT_RESET;

  // one pc word, read as a number or as table coordinates
  typedef union packed {
    logic [PC_W-1:0] raw;          // arithmetic view
    struct packed {
      logic [HI_W-1:0]   hi;       // not stored
      logic [TAG_W-1:0]  tag;
      logic [IDX_W-1:0]  idx;
      logic [BANK_W-1:0] bank;
      logic [1:0]        off;      // byte offset
    } f;
  } pc_u;

  // decode stage request
  typedef struct packed {
    pc_u     pc;
    opcode_e op;
  } lookup_t;

  // execute stage report, valid is a one-cycle strobe
  typedef struct packed {
    logic            valid;
    logic            taken;
    logic            pred_taken;  // prediction carried down the pipe
    pc_u             pc;
    logic [PC_W-1:0] target;
  } resolve_t;

  typedef struct packed {
    logic             lookup_sel;
    logic [IDX_W-1:0] lookup_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic             update_en;
    logic [IDX_W-1:0] update_idx;
    logic [TAG_W-1:0] update_tag;
    logic             taken;
    logic [PC_W-1:0]  target;
  } bank_req_t;

  typedef struct packed {
    logic            hit_taken;
    logic [PC_W-1:0] target;
  } bank_pred_t;

  typedef struct packed {
    logic            taken;
    logic [PC_W-1:0] next_pc;
  } prediction_t;

  typedef struct packed {
    logic            flush;  // applies to decode and execute
    logic [PC_W-1:0] pc;
  } redirect_t;

endpackage

`default_nettype wire

//--- rtl/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor
  import bp_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  lookup_t     lookup,
  input  resolve_t    resolve,
  output prediction_t prediction,
  output redirect_t   redirect
);

  bank_req_t  [NBANKS-1:0] bank_req;
  bank_pred_t [NBANKS-1:0] bank_pred;

  branch_route u_route (
    .lookup   (lookup),
    .resolve  (resolve),
    .bank_req (bank_req)
  );

  // one bank per pc bank field value
  for (genvar g = 0; g < NBANKS; g++) begin : g_bank
    predictor_bank u_bank (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (bank_req[g]),
      .pred   (bank_pred[g])
    );
  end

  predict_select u_select (
    .lookup_pc  (lookup.pc),
    .bank_pred  (bank_pred),
    .resolve    (resolve),
    .prediction (prediction),
    .redirect   (redirect)
  );

endmodule

`default_nettype wire

//--- rtl/branch_route.sv
`timescale 1ns/1ps
`default_nettype none

module branch_route
  import rv_isa_pkg::*;
  import bp_pkg::*;
(
  input  lookup_t                 lookup,
  input  resolve_t                resolve,
  output bank_req_t [NBANKS-1:0]  bank_req
);

  logic              is_branch;
  logic [NBANKS-1:0] lookup_oh;
  logic [NBANKS-1:0] update_oh;

  // only conditional branches consult the table
  assign is_branch = (lookup.op == OP_BRANCH);

  // one-hot bank decode for both ports
  always_comb begin
    lookup_oh = '0;
    update_oh = '0;
    if (is_branch) begin
      lookup_oh[lookup.pc.f.bank] = 1'b1;
    end
    if (resolve.valid) begin
      update_oh[resolve.pc.f.bank] = 1'b1;
    end
  end

  // index, tag and outcome fan out to every bank, selects stay one-hot
  always_comb begin
    for (int b = 0; b < NBANKS; b++) begin
      bank_req[b].lookup_sel = lookup_oh[b];
      bank_req[b].lookup_idx = lookup.pc.f.idx;
      bank_req[b].lookup_tag = lookup.pc.f.tag;
      bank_req[b].update_en  = update_oh[b];
      bank_req[b].update_idx = resolve.pc.f.idx;
      bank_req[b].update_tag = resolve.pc.f.tag;
      bank_req[b].taken      = resolve.taken;
      bank_req[b].target     = resolve.target;
    end
  end

endmodule

`default_nettype wire

//--- rtl/predict_select.sv
`timescale 1ns/1ps
`default_nettype none

module predict_select
  import rv_isa_pkg::*;
  import bp_pkg::*;
(
  input  pc_u                     lookup_pc,
  input  bank_pred_t [NBANKS-1:0] bank_pred,
  input  resolve_t                resolve,
  output prediction_t             prediction,
  output redirect_t               redirect
);

  bank_pred_t      sel;
  logic [PC_W-1:0] lookup_seq_pc;
  logic [PC_W-1:0] resolve_seq_pc;
  logic            mispredict;

  // only the addressed bank can have its select raised
  assign sel = bank_pred[lookup_pc.f.bank];

  assign lookup_seq_pc  = lookup_pc.raw + PC_W'(INSN_BYTES);
  assign resolve_seq_pc = resolve.pc.raw + PC_W'(INSN_BYTES);

  // either direction of a wrong guess
  assign mispredict = resolve.taken ^ resolve.pred_taken;

  always_comb begin
    prediction.taken   = sel.hit_taken;
    prediction.next_pc = sel.hit_taken ? sel.target : lookup_seq_pc;
  end

  always_comb begin
    redirect.flush = resolve.valid && mispredict;
    redirect.pc    = resolve.taken ? resolve.target : resolve_seq_pc;  // meaningful under flush
  end

endmodule

`default_nettype wire

//--- rtl/predictor_bank.sv
`timescale 1ns/1ps
`default_nettype none

module predictor_bank
  import bp_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  bank_req_t  req,
  output bank_pred_t pred
);

  logic [NENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]    tag_q    [NENTRIES];
  logic [1:0]          cnt_q    [NENTRIES];
  logic [PC_W-1:0]     target_q [NENTRIES];

  logic       up_hit;
  logic [1:0] up_cnt;
  logic       lu_hit;

  // 2-bit direction counter, upper bit is the prediction
  function automatic logic [1:0] step_cnt(input logic [1:0] cnt, input logic taken);
    logic [1:0] nxt;
    case (cnt)
      2'b00:   nxt = taken ? 2'b01 : 2'b00;
      2'b01:   nxt = taken ? 2'b11 : 2'b00;
      2'b10:   nxt = taken ? 2'b11 : 2'b00;
      default: nxt = taken ? 2'b11 : 2'b10;  // 11 only drops one step
    endcase
    return nxt;
  endfunction

  assign up_hit = valid_q[req.update_idx] && (tag_q[req.update_idx] == req.update_tag);

  // a miss allocates one step away from the reset state
  assign up_cnt = up_hit ? step_cnt(cnt_q[req.update_idx], req.taken)
                         : step_cnt(CNT_RESET, req.taken);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (req.update_en) begin
      valid_q[req.update_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req.update_en) begin
      tag_q[req.update_idx] <= req.update_tag;  // same tag on a hit
      cnt_q[req.update_idx] <= up_cnt;
      if (!up_hit || req.taken) begin
        target_q[req.update_idx] <= req.target;
      end
    end
  end

  // read side sees the registered table, so same-cycle updates are not visible
  assign lu_hit = req.lookup_sel && valid_q[req.lookup_idx]
               && (tag_q[req.lookup_idx] == req.lookup_tag);

  always_comb begin
    pred.hit_taken = lu_hit && cnt_q[req.lookup_idx][1];
    pred.target    = target_q[req.lookup_idx];
  end

endmodule

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int INSN_W     = 32;
  localparam int INSN_BYTES = INSN_W / 8;  // sequential pc step

  // RV32I major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_FENCE  = 7'b0001111,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_OP     = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,  // beq/bne/blt/bge/bltu/bgeu
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module tb_branch_predictor \
  --Mdir "$OBJ" -o tb_branch_predictor \
  -f all.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$OBJ/tb_branch_predictor" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim/bp_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module bp_assertions
  import rv_isa_pkg::*;
  import bp_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input lookup_t     lookup,
  input resolve_t    resolve,
  input prediction_t prediction,
  input redirect_t   redirect
);

  // a flush only comes from a resolved branch
  a_flush_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
    redirect.flush |-> resolve.valid)
    else $error("flush high without a resolve strobe");

  a_taken_needs_branch: assert property (@(posedge clk) disable iff (!arst_n)
    prediction.taken |-> (lookup.op == OP_BRANCH))
    else $error("taken predicted for a non-branch opcode");

  a_known_outputs: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(prediction) && !$isunknown(redirect.flush))
    else $error("prediction or flush unknown after reset");

endmodule

bind branch_predictor bp_assertions u_assertions (
  .clk        (clk),
  .arst_n     (arst_n),
  .lookup     (lookup),
  .resolve    (resolve),
  .prediction (prediction),
  .redirect   (redirect)
);

`default_nettype wire

//--- sim/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_macros.svh"

module tb_branch_predictor
  import rv_isa_pkg::*;
  import bp_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 4;
  localparam int POOL_SIZE       = 24;
  localparam int DIRECTED_CYCLES = 64;  // upper bound on the directed part
  localparam int RAND_CYCLES     = 2000;
  localparam int MAX_CYCLES = (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES) * 21 / 20;
  localparam int TABLE_SIZE = `BP_BANKS * `BP_ENTRIES;

  logic        clk;
  logic        arst_n;
  lookup_t     lookup;
  resolve_t    resolve;
  prediction_t prediction;
  redirect_t   redirect;

  // reference table, flat index is bank * entries + index
  logic        m_valid [TABLE_SIZE];
  logic [7:0]  m_tag   [TABLE_SIZE];
  logic [1:0]  m_cnt   [TABLE_SIZE];
  logic [31:0] m_tgt   [TABLE_SIZE];

  logic [31:0] pc_pool  [POOL_SIZE];
  logic [31:0] tgt_pool [POOL_SIZE];
  int unsigned bias     [POOL_SIZE];  // percent taken
  int          cycle_cnt = 0;

  branch_predictor DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .lookup     (lookup),
    .resolve    (resolve),
    .prediction (prediction),
    .redirect   (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run went past %0d clock cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "simulation aborted");
    end
  end

  function automatic logic [1:0] next_counter(input logic [1:0] cnt, input logic taken);
    if (taken) begin
      return (cnt == 2'b00) ? 2'b01 : 2'b11;
    end
    return (cnt == 2'b11) ? 2'b10 : 2'b00;
  endfunction

  // pc bits [3:2] pick the bank, [7:4] the entry, [15:8] are the tag
  function automatic int entry_of(input logic [31:0] pc);
    return int'(pc[3:2]) * `BP_ENTRIES + int'(pc[7:4]);
  endfunction

  function automatic lookup_t make_lookup(input opcode_e op, input logic [31:0] pc);
    lookup_t lu;
    lu.pc.raw = pc;
    lu.op     = op;
    return lu;
  endfunction

  function automatic resolve_t make_resolve(input logic valid, input logic taken,
                                            input logic pred, input logic [31:0] pc,
                                            input logic [31:0] tgt);
    resolve_t rs;
    rs.valid      = valid;
    rs.taken      = taken;
    rs.pred_taken = pred;
    rs.pc.raw     = pc;
    rs.target     = tgt;
    return rs;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic model_update(input resolve_t rs);
    int e;
    e = entry_of(rs.pc.raw);
    if (m_valid[e] && (m_tag[e] == rs.pc.raw[15:8])) begin
      m_cnt[e] = next_counter(m_cnt[e], rs.taken);
      if (rs.taken) begin
        m_tgt[e] = rs.target;
      end
    end else begin
      m_valid[e] = 1'b1;
      m_tag[e]   = rs.pc.raw[15:8];
      m_cnt[e]   = next_counter(`BP_CNT_RESET, rs.taken);
      m_tgt[e]   = rs.target;
    end
  endtask

  // table state is the one before this cycle's resolve lands
  task automatic run_cycle(input string name, input lookup_t lu, input resolve_t rs);
    int          e;
    logic        exp_taken;
    logic [31:0] exp_next;
    logic        exp_flush;
    @(negedge clk);
    lookup  = lu;
    resolve = rs;
    #(CLK_PERIOD / 4);
    e         = entry_of(lu.pc.raw);
    exp_taken = (lu.op == OP_BRANCH) && m_valid[e] && (m_tag[e] == lu.pc.raw[15:8])
                && m_cnt[e][1];
    exp_next  = exp_taken ? m_tgt[e] : lu.pc.raw + 32'd4;
    exp_flush = rs.valid && (rs.taken != rs.pred_taken);
    compare({name, " taken"}, 32'(exp_taken), 32'(prediction.taken));
    compare({name, " next_pc"}, exp_next, prediction.next_pc);
    compare({name, " flush"}, 32'(exp_flush), 32'(redirect.flush));
    if (exp_flush) begin
      compare({name, " redirect_pc"}, rs.taken ? rs.target : rs.pc.raw + 32'd4, redirect.pc);
    end
    if (rs.valid) begin
      model_update(rs);
    end
  endtask

  // groups of three share bank and index and differ in tag
  task automatic build_pool();
    logic [7:0] low_byte;
    low_byte = 8'h00;
    for (int i = 0; i < POOL_SIZE; i++) begin
      if (i % 3 == 0) begin
        low_byte = 8'($urandom) & 8'hFC;
      end
      pc_pool[i]  = {16'($urandom), 8'(i * 11), low_byte};
      tgt_pool[i] = $urandom & 32'hFFFF_FFFC;
      bias[i]     = $urandom_range(100);
    end
  endtask

  initial begin
    resolve_t    idle;
    resolve_t    rs;
    lookup_t     lu0;
    opcode_e     op;
    logic [31:0] lu_pc;
    int          i;
    int          j;
    void'($urandom(99825));
    arst_n  = 1'b0;
    lookup  = '0;
    resolve = '0;
    for (int k = 0; k < TABLE_SIZE; k++) begin
      m_valid[k] = 1'b0;
    end
    build_pool();
    idle = make_resolve(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
    lu0  = make_lookup(OP_BRANCH, pc_pool[0]);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (int k = 0; k < POOL_SIZE; k++) begin
      run_cycle("after_reset", make_lookup(OP_BRANCH, pc_pool[k]), idle);
      compare("after_reset literal", 32'd0, 32'(prediction.taken));
    end

    rs = make_resolve(1'b1, 1'b1, 1'b0, pc_pool[0], tgt_pool[0]);
    run_cycle("counter_walk", lu0, rs);
    run_cycle("counter_walk", lu0, rs);
    compare("counter_walk old contents", 32'd0, 32'(prediction.taken));
    run_cycle("counter_walk", lu0, idle);
    compare("counter_walk at 11", 32'd1, 32'(prediction.taken));
    rs = make_resolve(1'b1, 1'b0, 1'b1, pc_pool[0], tgt_pool[0]);
    run_cycle("counter_walk", lu0, rs);
    run_cycle("counter_walk", lu0, idle);
    compare("counter_walk at 10", 32'd1, 32'(prediction.taken));
    run_cycle("counter_walk", lu0, rs);
    run_cycle("counter_walk", lu0, idle);
    compare("counter_walk at 00", 32'd0, 32'(prediction.taken));

    rs = make_resolve(1'b1, 1'b1, 1'b0, pc_pool[0], tgt_pool[0]);
    run_cycle("non_branch", lu0, rs);
    run_cycle("non_branch", lu0, rs);
    run_cycle("non_branch", make_lookup(OP_JAL, pc_pool[0]), idle);
    compare("non_branch jal", 32'd0, 32'(prediction.taken));
    run_cycle("non_branch", make_lookup(OP_LOAD, pc_pool[0]), idle);
    compare("non_branch load", 32'd0, 32'(prediction.taken));
    run_cycle("non_branch", lu0, idle);
    compare("non_branch trained", 32'd1, 32'(prediction.taken));

    run_cycle("alias", lu0, make_resolve(1'b1, 1'b1, 1'b0, pc_pool[1], tgt_pool[1]));
    run_cycle("alias", lu0, idle);
    compare("alias replaced taken", 32'd0, 32'(prediction.taken));
    compare("alias replaced next_pc", pc_pool[0] + 32'd4, prediction.next_pc);

    run_cycle("redirect", lu0, make_resolve(1'b1, 1'b0, 1'b1, pc_pool[5], tgt_pool[5]));
    compare("redirect flush", 32'd1, 32'(redirect.flush));
    compare("redirect pc", pc_pool[5] + 32'd4, redirect.pc);
    run_cycle("redirect", lu0, make_resolve(1'b1, 1'b1, 1'b1, pc_pool[5], tgt_pool[5]));
    compare("redirect no flush", 32'd0, 32'(redirect.flush));

    for (int n = 0; n < RAND_CYCLES; n++) begin
      i = $urandom_range(POOL_SIZE - 1);
      j = ($urandom_range(3) == 0) ? i : $urandom_range(POOL_SIZE - 1);  // same-entry races
      case ($urandom_range(9))
        0:       op = OP_LOAD;
        1:       op = OP_JAL;
        2:       op = OP_OP;
        default: op = OP_BRANCH;
      endcase
      lu_pc = ($urandom_range(9) == 0) ? ($urandom & 32'hFFFF_FFFC) : pc_pool[i];
      rs = make_resolve($urandom_range(1) == 1, $urandom_range(99) < bias[j],
                        $urandom_range(1) == 1, pc_pool[j], tgt_pool[j]);
      run_cycle("random", make_lookup(op, lu_pc), rs);
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
